/* noc_mon_defs.svh */
`ifndef NOC_MON_DEFS_SVH
`define NOC_MON_DEFS_SVH

// ==============================
// mesh geometry
// ==============================
`define NOC_MESH_EDGE 4
`define NOC_ROUTERS   (`NOC_MESH_EDGE * `NOC_MESH_EDGE)

// flit fields
`define NOC_ID_W      4  // router id, x and y packed
`define NOC_PAYLOAD_W 4

// ==============================
// monitor
// ==============================
`define MON_CHANNELS  2
`define MON_CNT_W     4  // covers the router buffer depth

// wishbone register port
`define WB_ADR_W        4  // word address
`define WB_DAT_W        32
`define MON_REGS_PER_CH 4  // only 3 decoded

`endif

/* noc_mon_pkg.sv */
`include "noc_mon_defs.svh"

package noc_mon_pkg;

  // flit as seen on the local ports, also the colored expected flit
  typedef struct packed {
    logic [`NOC_ID_W-1:0]      src_id;
    logic [`NOC_PAYLOAD_W-1:0] payload;
    logic [`NOC_ID_W-1:0]      dest_id;
  } noc_flit_t;

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`WB_ADR_W-1:0] adr;
    logic [`WB_DAT_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic [`WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  // per channel watch setup
  typedef struct packed {
    logic [`NOC_ID_W-1:0]      src_id;
    logic [`NOC_ID_W-1:0]      dest_id;
    logic [`NOC_PAYLOAD_W-1:0] payload;
  } watch_cfg_t;

  typedef enum logic [1:0] {
    TRK_IDLE,
    TRK_WAIT_IN,   // counting injections
    TRK_WAIT_OUT,  // watched flit is in the mesh
    TRK_DONE
  } trk_state_e;

  typedef struct packed {
    trk_state_e            state;
    logic                  error;
    logic [`MON_CNT_W-1:0] count;
    logic                  seen_in;
    logic                  done;
  } trk_status_t;

  typedef enum logic [1:0] {
    REG_CTRL   = 2'd0,
    REG_WATCH  = 2'd1,
    REG_STATUS = 2'd2
  } reg_sel_e;

endpackage

/* noc_mon_regs.sv */
`include "noc_mon_defs.svh"

module noc_mon_regs
  import noc_mon_pkg::*;
(
  input  logic                                clk,
  input  logic                                reset,

  input  wb_req_t                             wb_req_i,
  output wb_rsp_t                             wb_rsp_o,

  output watch_cfg_t  [`MON_CHANNELS-1:0]     cfg_o,
  output logic        [`MON_CHANNELS-1:0]     arm_o,
  input  trk_status_t [`MON_CHANNELS-1:0]     status_i
);

  localparam int SEL_W = $clog2(`MON_REGS_PER_CH);
  localparam int CH_W  = `WB_ADR_W - SEL_W;
  localparam int CFG_W = $bits(watch_cfg_t);

  // ==============================
  // address decode
  // ==============================
  logic [CH_W-1:0]            adr_ch;
  reg_sel_e                   adr_sel;
  logic                       acc_start;  // first cycle of an access
  logic [`MON_CHANNELS-1:0]   ch_hit;
  logic [`MON_CHANNELS-1:0]   arm_d;
  logic [`MON_CHANNELS-1:0]   wr_watch;

  logic                       ack_q;
  logic [`MON_CHANNELS-1:0]   arm_q;
  watch_cfg_t [`MON_CHANNELS-1:0] cfg_q;
  logic [`WB_DAT_W-1:0]       rd_dat_d;
  logic [`WB_DAT_W-1:0]       rd_dat_q;

  assign adr_ch  = wb_req_i.adr[`WB_ADR_W-1:SEL_W];
  assign adr_sel = reg_sel_e'(wb_req_i.adr[SEL_W-1:0]);

  // the low cycle after ack keeps a held request from being acked twice
  assign acc_start = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  always_comb begin
    for (int i = 0; i < `MON_CHANNELS; i++) begin
      ch_hit[i]   = acc_start & (adr_ch == CH_W'(i));
      arm_d[i]    = ch_hit[i] & wb_req_i.we & (adr_sel == REG_CTRL) & wb_req_i.dat[0];
      wr_watch[i] = ch_hit[i] & wb_req_i.we & (adr_sel == REG_WATCH);
    end
  end

  // status word layout
  function automatic logic [`WB_DAT_W-1:0] pack_status(input trk_status_t s);
    logic [`WB_DAT_W-1:0] w;
    w      = '0;
    w[0]   = s.seen_in;
    w[1]   = s.done;
    w[2]   = s.error;
    w[7:4] = s.count;
    w[9:8] = s.state;
    return w;
  endfunction

  // ==============================
  // read mux
  // ==============================
  always_comb begin
    rd_dat_d = '0;  // unused addresses and CTRL read zero
    for (int i = 0; i < `MON_CHANNELS; i++) begin
      if (adr_ch == CH_W'(i)) begin
        case (adr_sel)
          REG_WATCH:  rd_dat_d[CFG_W-1:0] = cfg_q[i];
          REG_STATUS: rd_dat_d = pack_status(status_i[i]);
          default:    ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q <= 1'b0;
      arm_q <= '0;
      cfg_q <= '0;
    end else begin
      ack_q <= acc_start;
      arm_q <= arm_d;  // high during the ack cycle only
      for (int i = 0; i < `MON_CHANNELS; i++) begin
        if (wr_watch[i])
          cfg_q[i] <= watch_cfg_t'(wb_req_i.dat[CFG_W-1:0]);
      end
    end
  end

  // read data is sampled with the ack
  always_ff @(posedge clk) begin
    if (acc_start)
      rd_dat_q <= rd_dat_d;
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rd_dat_q;
  assign cfg_o        = cfg_q;
  assign arm_o        = arm_q;

endmodule

/* noc_link_tracker.sv */
`include "noc_mon_defs.svh"

module noc_link_tracker
  import noc_mon_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset,

  input  watch_cfg_t                       cfg_i,
  input  logic                             arm_i,

  // local injection ports, all routers
  input  logic      [`NOC_ROUTERS-1:0]     inj_v_i,
  input  logic      [`NOC_ROUTERS-1:0]     inj_yumi_i,
  input  noc_flit_t [`NOC_ROUTERS-1:0]     inj_flit_i,

  // local ejection ports, all routers
  input  logic      [`NOC_ROUTERS-1:0]     ej_v_i,
  input  logic      [`NOC_ROUTERS-1:0]     ej_ready_i,
  input  noc_flit_t [`NOC_ROUTERS-1:0]     ej_flit_i,

  output trk_status_t                      status_o
);

  trk_state_e             state_q, state_d;
  logic [`MON_CNT_W-1:0]  cnt_q, cnt_d;
  logic                   seen_in_q;
  logic                   seen_out_q;
  logic                   done_q;
  logic                   error_q;

  noc_flit_t              exp_flit;  // colored with the source id
  noc_flit_t              inj_flit;
  noc_flit_t              ej_flit;
  logic                   inj_hsk, ej_hsk;
  logic                   armed;
  logic                   incr, decr;
  logic                   sample_in;
  logic                   must_read;

  // ==============================
  // port select and match
  // ==============================
  assign exp_flit = '{src_id: cfg_i.src_id, payload: cfg_i.payload, dest_id: cfg_i.dest_id};

  assign inj_flit = inj_flit_i[cfg_i.src_id];
  assign inj_hsk  = inj_v_i[cfg_i.src_id] & inj_yumi_i[cfg_i.src_id];
  assign ej_flit  = ej_flit_i[cfg_i.dest_id];
  assign ej_hsk   = ej_v_i[cfg_i.dest_id] & ej_ready_i[cfg_i.dest_id];

  assign armed = (state_q == TRK_WAIT_IN) | (state_q == TRK_WAIT_OUT);

  // count everything for dest up to and including the watched flit
  assign incr      = armed & inj_hsk & ~seen_in_q & (inj_flit.dest_id == cfg_i.dest_id);
  assign sample_in = incr & (inj_flit == exp_flit);

  // flits injected before arming are not counted, so no decrement from zero
  assign decr = armed & ej_hsk & ~seen_out_q & (cnt_q != '0) &
                (ej_flit.src_id == cfg_i.src_id) & (ej_flit.dest_id == cfg_i.dest_id);

  assign must_read = decr & seen_in_q & (cnt_q == `MON_CNT_W'(1));  // last one out

  always_comb begin
    case ({incr, decr})
      2'b10:   cnt_d = cnt_q + `MON_CNT_W'(1);
      2'b01:   cnt_d = cnt_q - `MON_CNT_W'(1);
      default: cnt_d = cnt_q;  // both or neither
    endcase
  end

  // ==============================
  // fsm
  // ==============================
  always_comb begin
    state_d = state_q;
    case (state_q)
      TRK_WAIT_IN:  if (sample_in) state_d = TRK_WAIT_OUT;
      TRK_WAIT_OUT: if (must_read) state_d = TRK_DONE;
      default:      ;  // idle and done wait for arm
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= TRK_IDLE;
      cnt_q      <= '0;
      seen_in_q  <= 1'b0;
      seen_out_q <= 1'b0;
      done_q     <= 1'b0;
      error_q    <= 1'b0;
    end else if (arm_i) begin
      state_q    <= TRK_WAIT_IN;  // re-arm from any state
      cnt_q      <= '0;
      seen_in_q  <= 1'b0;
      seen_out_q <= 1'b0;
      done_q     <= 1'b0;
      error_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (sample_in)
        seen_in_q <= 1'b1;
      if (must_read) begin
        seen_out_q <= 1'b1;
        done_q     <= 1'b1;
        error_q    <= (ej_flit != exp_flit);  // final compare
      end
    end
  end

  assign status_o = '{state: state_q, error: error_q, count: cnt_q,
                      seen_in: seen_in_q, done: done_q};

endmodule

/* noc_link_monitor.sv */
`include "noc_mon_defs.svh"

module noc_link_monitor
  import noc_mon_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset,

  // mesh, observed only
  input  logic      [`NOC_ROUTERS-1:0]     inj_v_i,
  input  logic      [`NOC_ROUTERS-1:0]     inj_yumi_i,
  input  noc_flit_t [`NOC_ROUTERS-1:0]     inj_flit_i,
  input  logic      [`NOC_ROUTERS-1:0]     ej_v_i,
  input  logic      [`NOC_ROUTERS-1:0]     ej_ready_i,
  input  noc_flit_t [`NOC_ROUTERS-1:0]     ej_flit_i,

  // host
  input  wb_req_t                          wb_req_i,
  output wb_rsp_t                          wb_rsp_o
);

  watch_cfg_t  [`MON_CHANNELS-1:0] cfg;
  logic        [`MON_CHANNELS-1:0] arm;
  trk_status_t [`MON_CHANNELS-1:0] status;

  noc_mon_regs regs0 (
    .clk      (clk),
    .reset    (reset),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .cfg_o    (cfg),
    .arm_o    (arm),
    .status_i (status)
  );

  // ==============================
  // tracking channels
  // ==============================
  for (genvar ch = 0; ch < `MON_CHANNELS; ch++) begin : g_trk
    noc_link_tracker trk (
      .clk        (clk),
      .reset      (reset),
      .cfg_i      (cfg[ch]),
      .arm_i      (arm[ch]),
      .inj_v_i    (inj_v_i),
      .inj_yumi_i (inj_yumi_i),
      .inj_flit_i (inj_flit_i),
      .ej_v_i     (ej_v_i),
      .ej_ready_i (ej_ready_i),
      .ej_flit_i  (ej_flit_i),
      .status_o   (status[ch])
    );
  end

endmodule

/* tb_noc_link_monitor.sv */
`include "noc_mon_defs.svh"

module tb_noc_link_monitor
  import noc_mon_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ROWS = 4;

  logic                         clk;
  logic                         reset;
  logic      [`NOC_ROUTERS-1:0] inj_v, inj_yumi, ej_v, ej_ready;
  noc_flit_t [`NOC_ROUTERS-1:0] inj_flit, ej_flit;
  wb_req_t                      wb_req;
  wb_rsp_t                      wb_rsp;

  integer     seed;
  int         cycle_cnt, errors, err_mark, tests_run, tests_failed, n_rows;
  string      cur_test;
  watch_cfg_t cur_cfg;  // pair kept clear of background traffic

  // ==============================
  // stimulus table
  // ==============================
  string      row_name[ROWS];
  int         row_ch[ROWS], row_n[ROWS];
  watch_cfg_t row_cfg[ROWS];
  noc_flit_t  row_flit[ROWS][4];
  logic [7:0] row_ord[ROWS];  // ejection order at 2 bits per slot
  bit         row_corrupt[ROWS], row_noise[ROWS], row_done[ROWS], row_error[ROWS];

  noc_link_monitor dut0 (
    .clk(clk), .reset(reset),
    .inj_v_i(inj_v), .inj_yumi_i(inj_yumi), .inj_flit_i(inj_flit),
    .ej_v_i(ej_v), .ej_ready_i(ej_ready), .ej_flit_i(ej_flit),
    .wb_req_i(wb_req), .wb_rsp_o(wb_rsp)
  );

  always #4 clk = ~clk;
  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [`WB_ADR_W-1:0] reg_adr(input int ch, input reg_sel_e sel);
    return `WB_ADR_W'(ch * `MON_REGS_PER_CH + int'(sel));
  endfunction

  // picks a router clear of the watched pair and the busy port
  function automatic int noise_router(input int busy);
    int r;
    r = $unsigned($random(seed)) % `NOC_ROUTERS;
    for (int k = 0; k < `NOC_ROUTERS; k++) begin
      if (r == busy || r == cur_cfg.src_id || r == cur_cfg.dest_id)
        r = (r + 1) % `NOC_ROUTERS;
    end
    return r;
  endfunction

  task automatic add_row(input string name, input int ch, input watch_cfg_t cfg, input int n,
                         input noc_flit_t f0, f1, f2, f3, input logic [7:0] ord,
                         input bit corrupt, noise, exp_done, exp_error);
    row_name[n_rows] = name;
    row_ch[n_rows] = ch;
    row_cfg[n_rows] = cfg;
    row_n[n_rows] = n;
    row_flit[n_rows] = '{f0, f1, f2, f3};
    row_ord[n_rows] = ord;
    row_corrupt[n_rows] = corrupt;
    row_noise[n_rows] = noise;
    row_done[n_rows] = exp_done;
    row_error[n_rows] = exp_error;
    n_rows++;
  endtask

  // ==============================
  // checks
  // ==============================
  task automatic check_status(input string what, input trk_status_t exp,
                              input trk_status_t act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected %p actual %p", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_watch(input string what, input watch_cfg_t exp, input watch_cfg_t act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected %p actual %p", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_word(input string what, input logic [`WB_DAT_W-1:0] exp,
                            input logic [`WB_DAT_W-1:0] act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_ack(input string what, input bit got, input bit extra);
    if (!got)
      $display("%s: no ack for the %s access within 20 cycles", cur_test, what);
    else if (extra)
      $display("%s: ack for the %s access stayed high a second cycle", cur_test, what);
    if (!got || extra)
      errors++;
  endtask

  // ==============================
  // wishbone and mesh drivers
  // ==============================
  task automatic wb_access(input string what, input logic we, input logic [`WB_ADR_W-1:0] adr,
                           input logic [`WB_DAT_W-1:0] wdat, output logic [`WB_DAT_W-1:0] rdat);
    int waited;
    bit got;
    waited = 0;
    got = 1'b0;
    rdat = '0;
    @(posedge clk);
    #1;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    while (!got && waited < 20) begin
      @(posedge clk);
      #1;
      waited++;
      if (wb_rsp.ack) begin
        got = 1'b1;
        rdat = wb_rsp.dat;
      end
    end
    wb_req = '0;
    @(posedge clk);
    #1;
    check_ack(what, got, wb_rsp.ack);  // must have dropped again
  endtask

  task automatic wb_write(input string what, input logic [`WB_ADR_W-1:0] adr,
                          input logic [`WB_DAT_W-1:0] dat);
    logic [`WB_DAT_W-1:0] rd_ignored;
    wb_access(what, 1'b1, adr, dat, rd_ignored);
  endtask

  task automatic read_status(input int ch, output trk_status_t s);
    logic [`WB_DAT_W-1:0] w;
    wb_access("status", 1'b0, reg_adr(ch, REG_STATUS), '0, w);
    s.seen_in = w[0];
    s.done    = w[1];
    s.error   = w[2];
    s.count   = w[7:4];
    s.state   = trk_state_e'(w[9:8]);
  endtask

  task automatic wait_done(input int ch, output trk_status_t s);
    int start;
    start = cycle_cnt;
    s = '0;
    while (!s.done && cycle_cnt - start < 100)
      read_status(ch, s);
    if (!s.done) begin
      $display("%s: channel %0d did not report done within 100 cycles", cur_test, ch);
      errors++;
    end
  endtask

  task automatic mesh_clear();
    inj_v = '0;
    inj_yumi = '0;
    inj_flit = '0;
    ej_v = '0;
    ej_ready = '0;
    ej_flit = '0;
  endtask

  task automatic drive_noise(input int busy);
    logic [31:0] rnd;
    int r;
    r = noise_router(busy);
    rnd = $random(seed);
    inj_v[r] = 1'b1;
    inj_yumi[r] = 1'b1;
    inj_flit[r] = rnd[11:0];
    inj_flit[r].src_id = `NOC_ID_W'(r);
    r = noise_router(busy);
    rnd = $random(seed);
    ej_v[r] = 1'b1;
    ej_ready[r] = 1'b1;
    ej_flit[r] = rnd[11:0];
  endtask

  task automatic mesh_transfer(input noc_flit_t f, input bit eject, input bit noise);
    int r;
    r = eject ? int'(f.dest_id) : int'(f.src_id);
    for (int c = 0; c < 2; c++) begin  // one stall cycle before the handshake
      @(posedge clk);
      #1;
      mesh_clear();
      if (eject) begin
        ej_v[r] = 1'b1;
        ej_ready[r] = (c == 1);
        ej_flit[r] = f;
      end else begin
        inj_v[r] = 1'b1;
        inj_yumi[r] = (c == 1);
        inj_flit[r] = f;
      end
      if (noise)
        drive_noise(r);
    end
    @(posedge clk);
    #1;
    mesh_clear();
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == err_mark) begin
      $display("test %-18s ok", cur_test);
    end else begin
      $display("test %-18s FAILED", cur_test);
      tests_failed++;
    end
  endtask

  // ==============================
  // test sequences
  // ==============================
  task automatic run_reset_checks();
    trk_status_t act;
    logic [`WB_DAT_W-1:0] w;
    start_test("reset_values");
    for (int ch = 0; ch < `MON_CHANNELS; ch++) begin
      read_status(ch, act);
      check_status("status after reset", '0, act);
      wb_access("watch", 1'b0, reg_adr(ch, REG_WATCH), '0, w);
      check_watch("watch after reset", '0, watch_cfg_t'(w[11:0]));
    end
    finish_test();
  endtask

  task automatic run_register_checks();
    watch_cfg_t cfg;
    logic [`WB_DAT_W-1:0] w;
    start_test("register_access");
    cfg = {4'd5, 4'd10, 4'hC};  // src, dest, payload
    wb_write("watch", reg_adr(0, REG_WATCH), `WB_DAT_W'(cfg));
    wb_access("watch", 1'b0, reg_adr(0, REG_WATCH), '0, w);
    check_watch("watch readback", cfg, watch_cfg_t'(w[11:0]));
    wb_access("ctrl", 1'b0, reg_adr(0, REG_CTRL), '0, w);
    check_word("ctrl read", '0, w);
    wb_write("unused", reg_adr(3, REG_WATCH), 32'hFFF);  // no channel 3
    wb_access("unused", 1'b0, reg_adr(3, REG_WATCH), '0, w);
    check_word("unused read", '0, w);
    finish_test();
  endtask

  task automatic run_row(input int i);
    trk_status_t exp, act;
    noc_flit_t watched, f;
    int exp_cnt, ch;
    bit past_watched;
    ch = row_ch[i];
    cur_cfg = row_cfg[i];
    watched = {cur_cfg.src_id, cur_cfg.payload, cur_cfg.dest_id};  // colored with source
    exp_cnt = 0;
    past_watched = 1'b0;
    start_test(row_name[i]);
    wb_write("watch", reg_adr(ch, REG_WATCH), `WB_DAT_W'(cur_cfg));
    wb_write("arm", reg_adr(ch, REG_CTRL), 32'h1);
    exp = '0;
    exp.state = TRK_WAIT_IN;
    read_status(ch, act);
    check_status("after arm", exp, act);
    for (int k = 0; k < row_n[i]; k++) begin
      f = row_flit[i][k];
      mesh_transfer(f, 1'b0, row_noise[i]);
      if (!past_watched && f.src_id == cur_cfg.src_id && f.dest_id == cur_cfg.dest_id)
        exp_cnt++;
      if (f == watched)
        past_watched = 1'b1;
    end
    exp.state = TRK_WAIT_OUT;
    exp.count = `MON_CNT_W'(exp_cnt);
    exp.seen_in = 1'b1;
    read_status(ch, act);
    check_status("before ejection", exp, act);
    for (int k = 0; k < row_n[i]; k++) begin
      f = row_flit[i][row_ord[i][2*k +: 2]];
      if (row_corrupt[i] && f == watched)
        f.payload = f.payload ^ `NOC_PAYLOAD_W'(1);
      mesh_transfer(f, 1'b1, row_noise[i]);
    end
    wait_done(ch, act);
    exp.state = row_done[i] ? TRK_DONE : TRK_WAIT_OUT;
    exp.count = '0;
    exp.done = row_done[i];
    exp.error = row_error[i];
    check_status("final", exp, act);
    finish_test();
  endtask

  task automatic run_two_channels();
    trk_status_t exp, act;
    start_test("two_channels");
    wb_write("watch ch0", reg_adr(0, REG_WATCH), `WB_DAT_W'({4'd1, 4'd6, 4'hA}));
    wb_write("watch ch1", reg_adr(1, REG_WATCH), `WB_DAT_W'({4'd12, 4'd3, 4'h5}));
    wb_write("arm ch0", reg_adr(0, REG_CTRL), 32'h1);
    wb_write("arm ch1", reg_adr(1, REG_CTRL), 32'h1);
    mesh_transfer({4'd1, 4'hA, 4'd6}, 1'b0, 1'b0);
    mesh_transfer({4'd12, 4'h5, 4'd3}, 1'b0, 1'b0);
    mesh_transfer({4'd12, 4'h4, 4'd3}, 1'b1, 1'b0);  // ch1 payload damaged
    mesh_transfer({4'd1, 4'hA, 4'd6}, 1'b1, 1'b0);
    exp = '{state: TRK_DONE, error: 1'b0, count: '0, seen_in: 1'b1, done: 1'b1};
    wait_done(0, act);
    check_status("ch0 final", exp, act);
    exp.error = 1'b1;
    wait_done(1, act);
    check_status("ch1 final", exp, act);
    finish_test();
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    wb_req = '0;
    mesh_clear();
    seed = 77;
    cycle_cnt = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    n_rows = 0;
    cur_cfg = '0;
    // flits are src, payload, dest
    add_row("intact_in_order", 0, {4'd1, 4'd6, 4'hA}, 3, {4'd1, 4'h3, 4'd6},
            {4'd1, 4'h5, 4'd6}, {4'd1, 4'hA, 4'd6}, '0, 8'b00_10_01_00, 0, 0, 1, 0);
    add_row("corrupt_watched", 0, {4'd1, 4'd6, 4'hA}, 3, {4'd1, 4'h3, 4'd6},
            {4'd1, 4'h5, 4'd6}, {4'd1, 4'hA, 4'd6}, '0, 8'b00_10_01_00, 1, 0, 1, 1);
    add_row("background_traffic", 0, {4'd1, 4'd6, 4'hA}, 4, {4'd1, 4'h3, 4'd6},
            {4'd1, 4'h7, 4'd9}, {4'd1, 4'h5, 4'd6}, {4'd1, 4'hA, 4'd6}, 8'b01_11_10_00,
            0, 1, 1, 0);
    // middle flit comes from another source into the watched destination
    add_row("channel1_pair", 1, {4'd12, 4'd3, 4'h5}, 3, {4'd12, 4'h2, 4'd3},
            {4'd5, 4'h9, 4'd3}, {4'd12, 4'h5, 4'd3}, '0, 8'b00_10_01_00, 0, 0, 1, 0);
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    run_reset_checks();
    run_register_checks();
    for (int i = 0; i < n_rows; i++)
      run_row(i);
    run_two_channels();
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* noc_link_monitor.f */
+incdir+.
noc_mon_pkg.sv
noc_mon_regs.sv
noc_link_tracker.sv
noc_link_monitor.sv
tb_noc_link_monitor.sv

/* Bender.yml */
package:
  name: noc_link_monitor

export_include_dirs:
  - .

sources:
  - noc_mon_pkg.sv
  - noc_mon_regs.sv
  - noc_link_tracker.sv
  - noc_link_monitor.sv
  - target: test
    files:
      - tb_noc_link_monitor.sv
